// ==== files.f ====
verilog/mlsu_pkg.sv
verilog/mlsu_req_split.sv
verilog/mlsu_rbeat_queue.sv
verilog/mlsu_seq_load.sv
verilog/mlsu_top.sv
bench/mlsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module mlsu_tb -f files.f \
  -Mdir obj_dir -o mlsu_sim
if [ $? -ne 0 ]; then
  echo "build error"
  exit 1
fi

out=$(./obj_dir/mlsu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1

// ==== bench/mlsu_tb.sv ====
// ========================================
// Testbench for the matrix load sequencer
// Memory model, reference model, stimulus and output checker
// ========================================

`timescale 1ns/1ps
`default_nettype none

module mlsu_tb;

  localparam int unsigned ReqTmo  = 400;
  localparam int unsigned IdleTmo = 4000;
  localparam int unsigned BufW    = $bits(mlsu_pkg::seq_buf_t);

  logic                clk_i;
  logic                rst_ni;
  logic                req_valid_i;
  logic                req_ready_o;
  mlsu_pkg::load_req_t req_i;
  logic                ar_valid_o;
  logic                ar_ready_i;
  mlsu_pkg::axi_ar_t   ar_o;
  logic                r_valid_i;
  logic                r_ready_o;
  mlsu_pkg::axi_r_t    r_i;
  logic                out_valid_o;
  logic                out_ready_i;
  mlsu_pkg::seq_buf_t  out_o;

  int seed = 32'h58bd_753b;

  // Expected output entries, expected AR commands and R beats still to send
  mlsu_pkg::seq_buf_t exp_q[$];
  mlsu_pkg::axi_ar_t  exp_ar_q[$];
  mlsu_pkg::axi_r_t   beat_q[$];

  string test_name = "";
  int    test_errs = 0;
  int    out_seen  = 0;
  int    exp_total = 0;
  int    pass_cnt  = 0;
  int    fail_cnt  = 0;
  int    req_sent  = 0;
  int    ar_seen   = 0;
  bit    ready_hold  = 1'b0;
  bit    ready_rand  = 1'b0;
  bit    saw_r_stall = 1'b0;
  bit    timed_out   = 1'b0;

  mlsu_top #(
    .RQueueDepth (4)
  ) i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .ar_valid_o  (ar_valid_o),
    .ar_ready_i  (ar_ready_i),
    .ar_o        (ar_o),
    .r_valid_i   (r_valid_i),
    .r_ready_o   (r_ready_o),
    .r_i         (r_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_o       (out_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ========================================
  // Memory and reference model
  // ========================================

  // One nibble per nibble address, hashed from all address bits
  function automatic logic [3:0] mem_nibble(input logic [31:0] a);
    logic [31:0] h;
    h = a * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    h = h * 32'h85eb_ca6b;
    return h[31:28] ^ h[19:16];
  endfunction

  function automatic mlsu_pkg::axi_r_t mem_beat(input logic [31:0] nib_base, input logic last);
    mlsu_pkg::axi_r_t b;
    for (int i = 0; i < mlsu_pkg::BUS_NB; i++) begin
      b.data[i*4 +: 4] = mem_nibble(nib_base + 32'(i));
    end
    b.last = last;
    return b;
  endfunction

  // Entry k holds request nibbles k*32 onward, packed from nibble 0
  function automatic mlsu_pkg::seq_buf_t ref_entry(input logic [31:0] addr, input int len,
                                                   input int k);
    mlsu_pkg::seq_buf_t e;
    int n;
    e = '0;
    for (int i = 0; i < mlsu_pkg::LANE_NB; i++) begin
      n = k * int'(mlsu_pkg::LANE_NB) + i;
      if (n < len) begin
        e.nb[i*4 +: 4] = mem_nibble(addr + 32'(n));
        e.en[i]        = 1'b1;
      end
    end
    return e;
  endfunction

  // Byte address of the first beat and beats spanned minus one
  function automatic mlsu_pkg::axi_ar_t ref_ar(input logic [31:0] addr, input int len);
    mlsu_pkg::axi_ar_t a;
    int first_beat;
    int last_beat;
    first_beat = int'(addr / 16);
    last_beat  = int'((addr + 32'(len) - 1) / 16);
    a.addr = 32'(first_beat) * 8;
    a.len  = 4'(last_beat - first_beat);
    return a;
  endfunction

  // ========================================
  // Reporting
  // ========================================

  task automatic value_err(input string what, input logic [BufW-1:0] exp_v,
                           input logic [BufW-1:0] act_v);
    test_errs++;
    $display("ERR %s %s expected %0h actual %0h", test_name, what, exp_v, act_v);
  endtask

  task automatic note_err(input string msg);
    test_errs++;
    $display("%s: %s", test_name, msg);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
    out_seen  = 0;
    exp_total = 0;
  endtask

  task automatic end_test();
    if (out_seen != exp_total) value_err("entry count", exp_total, out_seen);
    if (test_errs == 0) begin
      pass_cnt++;
      $display("PASS %s", test_name);
    end else begin
      fail_cnt++;
      $display("FAIL %s with %0d errors", test_name, test_errs);
    end
  endtask

  task automatic finish_run();
    $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  task automatic timeout_err(input string what);
    $display("%s: timed out waiting for %s", test_name, what);
    fail_cnt++;
    timed_out = 1'b1;
  endtask

  // ========================================
  // Stimulus
  // ========================================

  task automatic send_request(input logic [31:0] addr, input int len);
    int cnt;
    int n_ent;
    bit acc;
    n_ent = (len + int'(mlsu_pkg::LANE_NB) - 1) / int'(mlsu_pkg::LANE_NB);
    for (int k = 0; k < n_ent; k++) begin
      exp_q.push_back(ref_entry(addr, len, k));
    end
    exp_total += n_ent;
    exp_ar_q.push_back(ref_ar(addr, len));
    req_sent++;
    req_i.addr  = addr;
    req_i.len   = len[mlsu_pkg::LEN_W-1:0];
    req_valid_i = 1'b1;
    cnt = 0;
    acc = 1'b0;
    while (!acc && cnt < ReqTmo) begin
      @(negedge clk_i);
      acc = req_ready_o;
      @(posedge clk_i);
      #2;
      cnt++;
    end
    req_valid_i = 1'b0;
    if (!acc) timeout_err("req_ready_o");
  endtask

  // Done once the splitter is idle and every expected entry came out
  task automatic wait_idle();
    int cnt;
    bit idle;
    cnt  = 0;
    idle = 1'b0;
    while (!idle && cnt < IdleTmo) begin
      @(negedge clk_i);
      idle = req_ready_o && !out_valid_o && !ar_valid_o && !r_valid_i &&
             (exp_q.size() == 0) && (beat_q.size() == 0);
      @(posedge clk_i);
      #2;
      cnt++;
    end
    if (!idle) timeout_err("the request to complete");
  endtask

  // AR responder, R beat source and out_ready_i driver
  initial begin : bus_model
    mlsu_pkg::axi_ar_t ar_s;
    mlsu_pkg::axi_ar_t ar_e;
    logic [31:0]       nib_base;
    logic              ar_hs;
    logic              r_hs;
    ar_ready_i  = 1'b0;
    r_valid_i   = 1'b0;
    r_i         = '0;
    out_ready_i = 1'b0;
    forever begin
      // Transfers of the coming edge are decided here
      @(negedge clk_i);
      ar_hs = ar_valid_o && ar_ready_i;
      r_hs  = r_valid_i && r_ready_o;
      ar_s  = ar_o;
      if (ready_hold && !r_ready_o) begin
        saw_r_stall = 1'b1;
      end
      @(posedge clk_i);
      #2;
      if (ar_hs) begin
        ar_seen++;
        if (exp_ar_q.size() == 0) begin
          note_err("AR command with no request pending");
        end else begin
          ar_e = exp_ar_q.pop_front();
          if (ar_s.addr !== ar_e.addr) value_err("ar addr", ar_e.addr, ar_s.addr);
          if (ar_s.len !== ar_e.len) value_err("ar len", ar_e.len, ar_s.len);
        end
        // Beats come from the address the DUT asked for
        nib_base = {ar_s.addr[30:0], 1'b0};
        for (int b = 0; b <= int'(ar_s.len); b++) begin
          beat_q.push_back(mem_beat(nib_base + 32'(b * 16), b == int'(ar_s.len)));
        end
      end
      if (r_hs) begin
        beat_q.delete(0);
        r_valid_i = 1'b0;
      end
      if (!r_valid_i && (beat_q.size() != 0) && (($random(seed) & 3) != 0)) begin
        r_i       = beat_q[0];
        r_valid_i = 1'b1;
      end
      ar_ready_i = 1'b1;
      if (ready_hold) begin
        out_ready_i = 1'b0;
      end else if (ready_rand) begin
        out_ready_i = (($random(seed) & 3) != 0);
      end else begin
        out_ready_i = 1'b1;
      end
    end
  end

  // Output checker
  initial begin : compare_out
    mlsu_pkg::seq_buf_t exp_e;
    mlsu_pkg::seq_buf_t got;
    forever begin
      @(negedge clk_i);
      if (rst_ni && out_valid_o && out_ready_i) begin
        got = out_o;
        out_seen++;
        if (exp_q.size() == 0) begin
          note_err("output entry arrived with none expected");
        end else begin
          exp_e = exp_q.pop_front();
          if (got !== exp_e) value_err("out entry", exp_e, got);
        end
      end
    end
  end

  // ========================================
  // Test sequence
  // ========================================

  // Stops at the first wait that runs out of time
  task automatic run_tests();
    int unsigned r_off;
    int unsigned r_len;
    logic [31:0] r_addr;

    start_test("reset_state");
    @(negedge clk_i);
    if (out_valid_o !== 1'b0) value_err("out_valid_o", 0, out_valid_o);
    if (ar_valid_o !== 1'b0) value_err("ar_valid_o", 0, ar_valid_o);
    if (req_ready_o !== 1'b1) value_err("req_ready_o", 1, req_ready_o);
    if (r_ready_o !== 1'b1) value_err("r_ready_o", 1, r_ready_o);
    @(posedge clk_i);
    #2;
    end_test();

    start_test("aligned_64");
    send_request(32'h0000_1000, 64);
    if (timed_out) return;
    wait_idle();
    if (timed_out) return;
    end_test();

    start_test("head_offset_5_len_40");
    send_request(32'h0000_2005, 40);
    if (timed_out) return;
    wait_idle();
    if (timed_out) return;
    end_test();

    start_test("short_in_beat");
    send_request(32'h0000_3003, 7);
    if (timed_out) return;
    wait_idle();
    if (timed_out) return;
    end_test();

    // Output held low so the ping-pong buffer and the R queue fill up
    start_test("out_stall_256");
    saw_r_stall = 1'b0;
    ready_hold  = 1'b1;
    send_request(32'h0000_4000, 256);
    if (timed_out) return;
    repeat (40) @(posedge clk_i);
    #2;
    ready_hold = 1'b0;
    wait_idle();
    if (timed_out) return;
    if (!saw_r_stall) note_err("r_ready_o never dropped while the output was held");
    end_test();

    start_test("random_b2b");
    ready_rand = 1'b1;
    for (int t = 0; t < 20; t++) begin
      r_off  = $unsigned($random(seed)) % 16;
      r_len  = 1 + $unsigned($random(seed)) % (256 - r_off);
      r_addr = ($unsigned($random(seed)) & 32'h0fff_fff0) | r_off;
      send_request(r_addr, int'(r_len));
      if (timed_out) return;
    end
    wait_idle();
    if (timed_out) return;
    ready_rand = 1'b0;
    end_test();

    start_test("ar_commands");
    if (ar_seen != req_sent) value_err("ar count", req_sent, ar_seen);
    if (exp_ar_q.size() != 0) note_err("some requests never issued an AR command");
    end_test();
  endtask

  initial begin : main
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    run_tests();
    finish_run();
  end

endmodule

`default_nettype wire

// ==== verilog/mlsu_top.sv ====
// ======================================
// Matrix load sequencer top level
// Splitter, R beat queue and sequential packer
// ======================================

`timescale 1ns/1ps
`default_nettype none

module mlsu_top #(
  parameter int unsigned RQueueDepth = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Load request
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  mlsu_pkg::load_req_t   req_i,

  // AXI read address and data
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  output mlsu_pkg::axi_ar_t     ar_o,
  input  logic                  r_valid_i,
  output logic                  r_ready_o,
  input  mlsu_pkg::axi_r_t      r_i,

  // Packed lane entries
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output mlsu_pkg::seq_buf_t    out_o
);

  logic                txn_valid, txn_ready;
  mlsu_pkg::txn_ctrl_t txn_ctrl;
  logic                beat_valid, beat_ready;
  mlsu_pkg::axi_r_t    beat;

  mlsu_req_split i_split (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req_i),
    .ar_valid_o   (ar_valid_o),
    .ar_ready_i   (ar_ready_i),
    .ar_o         (ar_o),
    .txn_valid_o  (txn_valid),
    .txn_ready_i  (txn_ready),
    .txn_ctrl_o   (txn_ctrl)
  );

  mlsu_rbeat_queue #(
    .Depth (RQueueDepth)
  ) i_rqueue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_valid_i (r_valid_i),
    .push_ready_o (r_ready_o),
    .push_i       (r_i),
    .pop_valid_o  (beat_valid),
    .pop_ready_i  (beat_ready),
    .pop_o        (beat)
  );

  mlsu_seq_load i_seq (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .txn_valid_i  (txn_valid),
    .txn_ready_o  (txn_ready),
    .txn_ctrl_i   (txn_ctrl),
    .beat_valid_i (beat_valid),
    .beat_ready_o (beat_ready),
    .beat_i       (beat),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_o        (out_o)
  );

endmodule

`default_nettype wire

// ==== verilog/mlsu_seq_load.sv ====
// ======================================
// Sequential packer
// Trims R beats to the request window and packs nibbles into a
// two-entry ping-pong lane buffer
// ======================================

`timescale 1ns/1ps
`default_nettype none

module mlsu_seq_load (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  txn_valid_i,
  output logic                  txn_ready_o,
  input  mlsu_pkg::txn_ctrl_t   txn_ctrl_i,

  input  logic                  beat_valid_i,
  output logic                  beat_ready_o,
  input  mlsu_pkg::axi_r_t      beat_i,

  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output mlsu_pkg::seq_buf_t    out_o
);

  localparam int unsigned BusW   = mlsu_pkg::BUS_NB_W;
  localparam int unsigned LaneW  = mlsu_pkg::LANE_NB_W;
  localparam int unsigned LaneNb = mlsu_pkg::LANE_NB;
  localparam int unsigned HiW    = BusW + 1;
  localparam int unsigned CntW   = LaneW + 1;

  mlsu_pkg::seq_state_e state_q, state_d;

  // Ping-pong entries
  mlsu_pkg::seq_buf_t lane_buf_q [2];
  mlsu_pkg::seq_buf_t lane_buf_d [2];

  // Pointer bit 1 is the wrap flag, bit 0 the entry index
  logic [1:0]       enq_ptr_q, deq_ptr_q;
  logic             enq_idx, deq_idx;
  logic             buf_full, buf_empty;
  logic             enq, deq;

  // Nibbles already taken from a split beat
  logic [BusW-1:0]  bus_cnt_q, bus_cnt_d;
  // Next free nibble in the current entry
  logic [LaneW-1:0] lane_ptr_q, lane_ptr_d;

  logic [BusW-1:0]  lo_nb;
  logic [HiW-1:0]   hi_nb;
  logic [CntW-1:0]  bus_avail;
  logic [CntW-1:0]  lane_free;
  logic [CntW-1:0]  n_cmt;
  logic [BusW-1:0]  start;
  logic             final_beat;
  logic             do_cmt;
  logic             consume;

  // ======================================
  // Lane buffer status
  // ======================================

  assign enq_idx   = enq_ptr_q[0];
  assign deq_idx   = deq_ptr_q[0];
  assign buf_empty = (enq_ptr_q == deq_ptr_q);
  assign buf_full  = (enq_idx == deq_idx) && (enq_ptr_q[1] != deq_ptr_q[1]);

  assign out_valid_o = !buf_empty;
  assign out_o       = lane_buf_q[deq_idx];
  assign deq         = out_valid_o && out_ready_i;

  // Descriptor and beat leave together
  assign txn_ready_o  = consume;
  assign beat_ready_o = consume;

  assign final_beat = (txn_ctrl_i.rmn_beat == '0);

  // ======================================
  // Packing
  // ======================================

  always_comb begin
    int idx;
    state_d    = state_q;
    bus_cnt_d  = bus_cnt_q;
    lane_ptr_d = lane_ptr_q;
    lane_buf_d = lane_buf_q;
    enq        = 1'b0;
    consume    = 1'b0;
    do_cmt     = 1'b0;
    lo_nb      = '0;
    hi_nb      = '0;
    bus_avail  = '0;
    lane_free  = '0;
    n_cmt      = '0;
    start      = '0;
    idx        = 0;

    unique case (state_q)
      mlsu_pkg::SEQ_IDLE: begin
        if (txn_valid_i) begin
          state_d = mlsu_pkg::SEQ_SERIAL;
        end
      end
      mlsu_pkg::SEQ_SERIAL: begin
        do_cmt = txn_valid_i && beat_valid_i && !buf_full;
        if (do_cmt) begin
          // Window of request nibbles in this beat
          lo_nb     = txn_ctrl_i.is_head ? txn_ctrl_i.offset : '0;
          hi_nb     = final_beat ? txn_ctrl_i.lb_n : HiW'(mlsu_pkg::BUS_NB);
          bus_avail = CntW'(hi_nb) - CntW'(lo_nb) - CntW'(bus_cnt_q);
          lane_free = CntW'(LaneNb) - CntW'(lane_ptr_q);
          start     = lo_nb + bus_cnt_q;

          if (bus_avail > lane_free) begin
            // Fill and close the entry, keep the beat for next cycle
            n_cmt      = lane_free;
            bus_cnt_d  = bus_cnt_q + BusW'(lane_free);
            lane_ptr_d = '0;
            enq        = 1'b1;
          end else begin
            n_cmt      = bus_avail;
            bus_cnt_d  = '0;
            lane_ptr_d = lane_ptr_q + LaneW'(bus_avail);
            consume    = 1'b1;
            // Entry just filled up, or the request ends here
            if ((bus_avail == lane_free) || final_beat) begin
              enq        = 1'b1;
              lane_ptr_d = '0;
            end
            if (final_beat) begin
              state_d = mlsu_pkg::SEQ_IDLE;
            end
          end

          for (int i = 0; i < LaneNb; i++) begin
            if ((i >= int'(lane_ptr_q)) && (i < int'(lane_ptr_q) + int'(n_cmt))) begin
              idx = i - int'(lane_ptr_q) + int'(start);
              lane_buf_d[enq_idx].nb[i*4 +: 4] = beat_i.data[idx*4 +: 4];
              lane_buf_d[enq_idx].en[i]        = 1'b1;
            end
          end
        end
      end
      default: begin
        state_d = mlsu_pkg::SEQ_IDLE;
      end
    endcase

    // A dequeued entry starts empty for its next fill
    if (deq) begin
      lane_buf_d[deq_idx] = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= mlsu_pkg::SEQ_IDLE;
      bus_cnt_q     <= '0;
      lane_ptr_q    <= '0;
      enq_ptr_q     <= '0;
      deq_ptr_q     <= '0;
      lane_buf_q[0] <= '0;
      lane_buf_q[1] <= '0;
    end else begin
      state_q    <= state_d;
      bus_cnt_q  <= bus_cnt_d;
      lane_ptr_q <= lane_ptr_d;
      enq_ptr_q  <= enq_ptr_q + {1'b0, enq};
      deq_ptr_q  <= deq_ptr_q + {1'b0, deq};
      lane_buf_q <= lane_buf_d;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mlsu_rbeat_queue.sv ====
// ======================================
// Read-beat queue
// Circular FIFO for R beats with wrap-flag pointers
// ======================================

`timescale 1ns/1ps
`default_nettype none

module mlsu_rbeat_queue #(
  parameter int unsigned Depth = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              push_valid_i,
  output logic              push_ready_o,
  input  mlsu_pkg::axi_r_t  push_i,

  output logic              pop_valid_o,
  input  logic              pop_ready_i,
  output mlsu_pkg::axi_r_t  pop_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  typedef struct packed {
    logic            flag;
    logic [PtrW-1:0] idx;
  } ptr_t;

  mlsu_pkg::axi_r_t mem_q [Depth];
  ptr_t             wr_ptr_q, rd_ptr_q;
  logic             push, pop;

  // Step a pointer, toggling the flag on wrap
  function automatic ptr_t ptr_inc(input ptr_t p);
    ptr_t r;
    r = p;
    if (p.idx == PtrW'(Depth - 1)) begin
      r.idx  = '0;
      r.flag = ~p.flag;
    end else begin
      r.idx = p.idx + 1'b1;
    end
    return r;
  endfunction

  // Same index with different flags means full
  assign push_ready_o = !((wr_ptr_q.idx == rd_ptr_q.idx) && (wr_ptr_q.flag != rd_ptr_q.flag));
  assign pop_valid_o  = (wr_ptr_q != rd_ptr_q);
  assign pop_o        = mem_q[rd_ptr_q.idx];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q.idx] <= push_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mlsu_req_split.sv ====
// ======================================
// Request splitter
// Turns one load request into an AR burst and per-beat descriptors
// ======================================

`timescale 1ns/1ps
`default_nettype none

module mlsu_req_split (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  mlsu_pkg::load_req_t   req_i,

  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  output mlsu_pkg::axi_ar_t     ar_o,

  output logic                  txn_valid_o,
  input  logic                  txn_ready_i,
  output mlsu_pkg::txn_ctrl_t   txn_ctrl_o
);

  localparam int unsigned BusW  = mlsu_pkg::BUS_NB_W;
  localparam int unsigned SpanW = mlsu_pkg::LEN_W + 1;
  localparam int unsigned LbW   = mlsu_pkg::BUS_NB_W + 1;

  mlsu_pkg::split_state_e state_q, state_d;
  mlsu_pkg::load_req_t    req_q;
  logic [3:0]             rmn_q, rmn_d;
  logic                   head_q, head_d;

  logic [BusW-1:0]        offset;
  logic [SpanW-1:0]       span;
  logic [SpanW-1:0]       span_m1;
  logic [3:0]             beats_m1;
  logic [LbW-1:0]         lb_n;

  // ======================================
  // Burst geometry
  // ======================================

  assign offset  = req_q.addr[BusW-1:0];
  // Nibbles from the aligned beat start to the request end
  assign span    = SpanW'(offset) + SpanW'(req_q.len);
  assign span_m1 = span - 1'b1;
  // Offset plus len must fit in 16 beats
  assign beats_m1 = span_m1[BusW +: 4];
  assign lb_n     = (span[BusW-1:0] == '0) ? LbW'(mlsu_pkg::BUS_NB) : {1'b0, span[BusW-1:0]};

  // Nibble address to beat-aligned byte address
  assign ar_o.addr = {1'b0, req_q.addr[mlsu_pkg::ADDR_W-1:BusW], {(BusW-1){1'b0}}};
  assign ar_o.len  = beats_m1;

  assign txn_ctrl_o.is_head  = head_q;
  assign txn_ctrl_o.rmn_beat = rmn_q;
  assign txn_ctrl_o.offset   = offset;
  assign txn_ctrl_o.lb_n     = lb_n;

  // ======================================
  // FSM
  // ======================================

  always_comb begin
    state_d     = state_q;
    rmn_d       = rmn_q;
    head_d      = head_q;
    req_ready_o = 1'b0;
    ar_valid_o  = 1'b0;
    txn_valid_o = 1'b0;

    unique case (state_q)
      mlsu_pkg::SPL_IDLE: begin
        req_ready_o = 1'b1;
        if (req_valid_i) begin
          state_d = mlsu_pkg::SPL_AR;
        end
      end
      mlsu_pkg::SPL_AR: begin
        ar_valid_o = 1'b1;
        if (ar_ready_i) begin
          state_d = mlsu_pkg::SPL_DESC;
          rmn_d   = beats_m1;
          head_d  = 1'b1;
        end
      end
      mlsu_pkg::SPL_DESC: begin
        txn_valid_o = 1'b1;
        if (txn_ready_i) begin
          head_d = 1'b0;
          if (rmn_q == '0) begin
            state_d = mlsu_pkg::SPL_IDLE;
          end else begin
            rmn_d = rmn_q - 1'b1;
          end
        end
      end
      default: begin
        state_d = mlsu_pkg::SPL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= mlsu_pkg::SPL_IDLE;
      rmn_q   <= '0;
      head_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      rmn_q   <= rmn_d;
      head_q  <= head_d;
    end
  end

  // Request latch
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mlsu_pkg.sv ====
// ======================================
// Matrix load sequencer shared definitions
// Bus and lane sizes, channel structs and FSM state enums
// ======================================

`default_nettype none

package mlsu_pkg;

  // ======================================
  // Sizes
  // ======================================

  // Nibbles carried by one 64-bit R beat
  localparam int unsigned BUS_NB    = 16;
  localparam int unsigned BUS_NB_W  = 4;

  // One lane entry holds 128 bits
  localparam int unsigned LANE_NB   = 32;
  localparam int unsigned LANE_NB_W = 5;

  // Nibble address and request length
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned LEN_W     = 9;

  // ======================================
  // Channel payloads
  // ======================================

  // Load request, len is nonzero and at most 256
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } load_req_t;

  // Read address, byte address aligned to the beat
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [3:0]        len;
  } axi_ar_t;

  typedef struct packed {
    logic [BUS_NB*4-1:0] data;
    logic                last;
  } axi_r_t;

  // Per-beat descriptor from the splitter to the packer
  typedef struct packed {
    logic                is_head;
    logic [3:0]          rmn_beat;
    logic [BUS_NB_W-1:0] offset;
    logic [BUS_NB_W:0]   lb_n;
  } txn_ctrl_t;

  // Lane entry with its nibble enable mask
  typedef struct packed {
    logic [LANE_NB*4-1:0] nb;
    logic [LANE_NB-1:0]   en;
  } seq_buf_t;

  typedef enum logic [1:0] {
    SPL_IDLE,
    SPL_AR,
    SPL_DESC
  } split_state_e;

  typedef enum logic {
    SEQ_IDLE,
    SEQ_SERIAL
  } seq_state_e;

endpackage

`default_nettype wire
